// ==== common/csr_pkg.sv ====
package csr_pkg;

    // Basic widths of the CSR stage
    typedef logic [31:0] xlen_t;
    typedef logic [63:0] dword_t;
    typedef logic [11:0] csr_addr_t;
    typedef logic [2:0]  csr_cmd_t;

    // Command codes coming from decode
    localparam csr_cmd_t CSR_X     = 3'd0;
    localparam csr_cmd_t CSR_W     = 3'd1;
    localparam csr_cmd_t CSR_S     = 3'd2;
    localparam csr_cmd_t CSR_C     = 3'd3;
    localparam csr_cmd_t CSR_ECALL = 3'd4;
    localparam csr_cmd_t CSR_MRET  = 3'd5;

    // Counters and timers, read only
    localparam csr_addr_t CYCLE    = 12'hc00;
    localparam csr_addr_t TIME     = 12'hc01;
    localparam csr_addr_t CYCLEH   = 12'hc80;
    localparam csr_addr_t TIMEH    = 12'hc81;

    // Machine trap setup
    localparam csr_addr_t MSTATUS  = 12'h300;
    localparam csr_addr_t MISA     = 12'h301;
    localparam csr_addr_t MEDELEG  = 12'h302;
    localparam csr_addr_t MIDELEG  = 12'h303;
    localparam csr_addr_t MIE      = 12'h304;
    localparam csr_addr_t MTVEC    = 12'h305;
    localparam csr_addr_t MSTATUSH = 12'h310;

    // Machine trap handling
    localparam csr_addr_t MSCRATCH = 12'h340;
    localparam csr_addr_t MEPC     = 12'h341;
    localparam csr_addr_t MCAUSE   = 12'h342;
    localparam csr_addr_t MTVAL    = 12'h343;
    localparam csr_addr_t MIP      = 12'h344;

    // Privilege levels, hypervisor encoding 2'b10 unused
    typedef enum logic [1:0] {
        MODE_USER       = 2'b00,
        MODE_SUPERVISOR = 2'b01,
        MODE_MACHINE    = 2'b11
    } priv_mode_t;

    // Timer interrupt position, same in mie, mip and mideleg
    localparam int MIE_MTIE_BIT = 7;

    // Environment call cause from U-mode, mode is added on top
    localparam xlen_t MCAUSE_ECALL_U = 32'd8;

    // Writable mstatus bits, WPRI fields forced to zero
    localparam xlen_t MSTATUS_WMASK = 32'h807f_ffea;

    // Request leaving the issue stage
    typedef struct packed {
        csr_cmd_t  cmd;
        csr_addr_t addr;
        xlen_t     op1;
    } csr_req_t;

    // Trap related CSR state handed from file to trap unit
    typedef struct packed {
        xlen_t mtvec;
        xlen_t mepc;
        logic  mie_mtie;
        logic  mideleg_mtie;
    } trap_cfg_t;

endpackage

// ==== hdl/csr_counters.sv ====
`timescale 1ns/100ps

module csr_counters (
    input  logic            clk,
    input  logic            arst_n,
    input  csr_pkg::dword_t mtimecmp,
    output csr_pkg::dword_t cycle,
    output csr_pkg::dword_t mtime,
    output logic            timer_pending
);

    // Free running counters
    // mtime ticks at core clock, no prescaler
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cycle <= '0;
            mtime <= '0;
        end else begin
            cycle <= cycle + 64'd1;
            mtime <= mtime + 64'd1;
        end
    end

    // Unsigned compare against the timer compare register
    // Level stays high until software moves mtimecmp
    assign timer_pending = (mtime >= mtimecmp);

endmodule

// ==== csr_unit/csr_issue.sv ====
`timescale 1ns/100ps

module csr_issue (
    input  logic              clk,
    input  logic              arst_n,
    input  csr_pkg::csr_cmd_t csr_cmd,
    input  csr_pkg::xlen_t    op1_data,
    input  csr_pkg::xlen_t    imm_i,
    input  logic              branch_hazard,
    output csr_pkg::csr_req_t req
);

    import csr_pkg::*;

    csr_req_t req_d;

    // Squash on branch hazard
    // Killed slot gets all-ones address and operand
    always_comb begin
        if (branch_hazard) begin
            req_d.cmd  = CSR_X;
            req_d.addr = '1;
            req_d.op1  = '1;
        end else begin
            req_d.cmd  = csr_cmd;
            // CSR address sits in the low immediate bits
            req_d.addr = imm_i[11:0];
            req_d.op1  = op1_data;
        end
    end

    // Issue register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            req <= '{cmd: CSR_X, addr: '0, op1: '0};
        end else begin
            req <= req_d;
        end
    end

endmodule

// ==== csr_unit/csr_file.sv ====
`timescale 1ns/100ps

module csr_file (
    input  logic               clk,
    input  logic               arst_n,
    input  csr_pkg::csr_req_t  req,
    input  csr_pkg::dword_t    cycle,
    input  csr_pkg::dword_t    mtime,
    input  csr_pkg::xlen_t     mstatus_word,
    input  logic               mcause_we,
    input  csr_pkg::xlen_t     mcause_val,
    output csr_pkg::xlen_t     rdata,
    output csr_pkg::trap_cfg_t cfg,
    output logic               mstatus_we,
    output csr_pkg::xlen_t     wdata
);

    import csr_pkg::*;

    // Trap setup
    xlen_t     medeleg;
    logic      mideleg_mtie;
    logic      mie_meie;
    logic      mie_seie;
    logic      mie_mtie;
    logic      mie_stie;
    logic      mie_msie;
    logic      mie_ssie;
    xlen_t     mtvec;
    logic      mstatush_mbe;
    logic      mstatush_sbe;

    // Trap handling
    xlen_t     mscratch;
    xlen_t     mepc;
    xlen_t     mcause;
    xlen_t     mtval;
    xlen_t     mip;

    // Read path and delayed write bookkeeping
    xlen_t     mie_word;
    xlen_t     rdata_d;
    csr_req_t  saved;
    logic      write_en;

    // Enable bits scattered at odd positions
    always_comb begin
        mie_word               = '0;
        mie_word[11]           = mie_meie;
        mie_word[9]            = mie_seie;
        mie_word[MIE_MTIE_BIT] = mie_mtie;
        mie_word[5]            = mie_stie;
        mie_word[3]            = mie_msie;
        mie_word[1]            = mie_ssie;
    end

    // Read multiplexer
    // Info registers and anything unknown fall to zero
    always_comb begin
        case (req.addr)
            CYCLE:    rdata_d = cycle[31:0];
            TIME:     rdata_d = mtime[31:0];
            CYCLEH:   rdata_d = cycle[63:32];
            TIMEH:    rdata_d = mtime[63:32];
            MSTATUS:  rdata_d = mstatus_word;
            // No extensions advertised
            MISA:     rdata_d = '0;
            MEDELEG:  rdata_d = medeleg;
            MIDELEG:  rdata_d = xlen_t'(mideleg_mtie) << MIE_MTIE_BIT;
            MIE:      rdata_d = mie_word;
            MTVEC:    rdata_d = mtvec;
            MSTATUSH: rdata_d = {26'b0, mstatush_mbe, mstatush_sbe, 4'b0};
            MSCRATCH: rdata_d = mscratch;
            MEPC:     rdata_d = mepc;
            MCAUSE:   rdata_d = mcause;
            MTVAL:    rdata_d = mtval;
            MIP:      rdata_d = mip;
            default:  rdata_d = '0;
        endcase
    end

    // Read data and saved request, both one cycle after req
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rdata <= '0;
            saved <= '{cmd: CSR_X, addr: '0, op1: '0};
        end else begin
            rdata <= rdata_d;
            saved <= req;
        end
    end

    // Read-modify-write on the registered read value
    always_comb begin
        write_en = 1'b1;
        case (saved.cmd)
            CSR_W: wdata = saved.op1;
            CSR_S: wdata = rdata | saved.op1;
            CSR_C: wdata = rdata & ~saved.op1;
            default: begin
                write_en = 1'b0;
                wdata    = '0;
            end
        endcase
    end

    // mstatus lives in the trap unit
    assign mstatus_we = write_en && (saved.addr == MSTATUS);

    // Commit one cycle after the read
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            medeleg      <= '0;
            mideleg_mtie <= 1'b0;
            mie_meie     <= 1'b0;
            mie_seie     <= 1'b0;
            mie_mtie     <= 1'b0;
            mie_stie     <= 1'b0;
            mie_msie     <= 1'b0;
            mie_ssie     <= 1'b0;
            mtvec        <= '0;
            mstatush_mbe <= 1'b0;
            mstatush_sbe <= 1'b0;
            mscratch     <= '0;
            mepc         <= '0;
            mcause       <= '0;
            mtval        <= '0;
            mip          <= '0;
        end else begin
            if (write_en) begin
                case (saved.addr)
                    MEDELEG:  medeleg      <= wdata;
                    MIDELEG:  mideleg_mtie <= wdata[MIE_MTIE_BIT];
                    MIE: begin
                        mie_meie <= wdata[11];
                        mie_seie <= wdata[9];
                        mie_mtie <= wdata[MIE_MTIE_BIT];
                        mie_stie <= wdata[5];
                        mie_msie <= wdata[3];
                        mie_ssie <= wdata[1];
                    end
                    MTVEC:    mtvec        <= wdata;
                    MSTATUSH: begin
                        mstatush_mbe <= wdata[5];
                        mstatush_sbe <= wdata[4];
                    end
                    MSCRATCH: mscratch     <= wdata;
                    MEPC:     mepc         <= wdata;
                    MCAUSE:   mcause       <= wdata;
                    MTVAL:    mtval        <= wdata;
                    MIP:      mip          <= wdata;
                    // Read-only, unimplemented or owned elsewhere
                    default: ;
                endcase
            end
            // ECALL cause wins over a software write
            if (mcause_we) begin
                mcause <= mcause_val;
            end
        end
    end

    // Trap unit view of the file
    assign cfg.mtvec        = mtvec;
    assign cfg.mepc         = mepc;
    assign cfg.mie_mtie     = mie_mtie;
    assign cfg.mideleg_mtie = mideleg_mtie;

endmodule

// ==== csr_unit/csr_trap.sv ====
`timescale 1ns/100ps

module csr_trap (
    input  logic               clk,
    input  logic               arst_n,
    input  csr_pkg::csr_req_t  req,
    input  csr_pkg::trap_cfg_t cfg,
    input  logic               timer_pending,
    input  logic               interrupt_ready,
    input  logic               mstatus_we,
    input  csr_pkg::xlen_t     wdata,
    output csr_pkg::xlen_t     mstatus_word,
    output csr_pkg::priv_mode_t mode,
    output logic               mcause_we,
    output csr_pkg::xlen_t     mcause_val,
    output csr_pkg::csr_cmd_t  csr_cmd_out,
    output csr_pkg::xlen_t     trap_vector,
    output logic               stall_may_interrupt
);

    import csr_pkg::*;

    // RV32 mstatus layout, msb first
    typedef struct packed {
        logic       sd;
        logic [7:0] wpri_hi;
        logic       tsr;
        logic       tw;
        logic       tvm;
        logic       mxr;
        logic       sum;
        logic       mprv;
        logic [1:0] xs;
        logic [1:0] fs;
        logic [1:0] mpp;
        logic [1:0] vs;
        logic       spp;
        logic       mpie;
        logic       ube;
        logic       spie;
        logic       wpri_4;
        logic       mie;
        logic       wpri_2;
        logic       sie;
        logic       wpri_0;
    } mstatus_t;

    mstatus_t mstatus;
    logic     take_irq;

    assign mstatus_word = mstatus;

    // Timer interrupt may fire
    // M-mode needs no delegation and MIE, S-mode needs delegation and SIE
    assign stall_may_interrupt = timer_pending && cfg.mie_mtie &&
        ((mode == MODE_MACHINE && !cfg.mideleg_mtie && mstatus.mie) ||
         (mode == MODE_SUPERVISOR && cfg.mideleg_mtie && mstatus.sie));

    assign take_irq = stall_may_interrupt && interrupt_ready;

    // ECALL cause strobe, dropped when an interrupt takes the slot
    assign mcause_we  = (req.cmd == CSR_ECALL) && !take_irq;
    assign mcause_val = MCAUSE_ECALL_U + xlen_t'(mode);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mode        <= MODE_MACHINE;
            mstatus     <= '{mpp: MODE_MACHINE, default: '0};
            csr_cmd_out <= CSR_X;
            trap_vector <= '0;
        end else begin
            // Software write first, trap events below override fields
            if (mstatus_we) begin
                mstatus <= mstatus_t'(wdata & MSTATUS_WMASK);
                // No hypervisor, legalize MPP
                if (wdata[12:11] == 2'b10) begin
                    mstatus.mpp <= MODE_MACHINE;
                end
            end

            if (take_irq) begin
                csr_cmd_out <= CSR_ECALL;
                mstatus.mpp <= mode;
                // No stvec, both targets use mtvec
                trap_vector <= cfg.mtvec;
                if (!cfg.mideleg_mtie) begin
                    mode         <= MODE_MACHINE;
                    mstatus.mpie <= mstatus.mie;
                    mstatus.mie  <= 1'b0;
                end else begin
                    mode         <= MODE_SUPERVISOR;
                    mstatus.spie <= mstatus.sie;
                    mstatus.sie  <= 1'b0;
                end
            end else begin
                csr_cmd_out <= req.cmd;
                case (req.cmd)
                    CSR_ECALL: begin
                        trap_vector <= cfg.mtvec;
                        mode        <= MODE_MACHINE;
                    end
                    CSR_MRET: begin
                        trap_vector  <= cfg.mepc;
                        mode         <= priv_mode_t'(mstatus.mpp);
                        mstatus.mpp  <= MODE_USER;
                        mstatus.mie  <= mstatus.mpie;
                        // Returning below M drops MPRV
                        if (mstatus.mpp != MODE_MACHINE) begin
                            mstatus.mprv <= 1'b0;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

// ==== hdl/csr_pipe.sv ====
`timescale 1ns/100ps

module csr_pipe (
    input  logic              clk,
    input  logic              arst_n,
    input  csr_pkg::csr_cmd_t csr_cmd,
    input  csr_pkg::xlen_t    op1_data,
    input  csr_pkg::xlen_t    imm_i,
    input  logic              branch_hazard,
    input  logic              interrupt_ready,
    input  csr_pkg::dword_t   mtimecmp,
    output csr_pkg::csr_cmd_t csr_cmd_out,
    output csr_pkg::xlen_t    csr_rdata,
    output csr_pkg::xlen_t    trap_vector,
    output logic              stall_may_interrupt
);

    import csr_pkg::*;

    // Counter values
    dword_t    cycle;
    dword_t    mtime;
    logic      timer_pending;

    // Issue to execute
    csr_req_t  req;

    // File and trap unit exchange
    trap_cfg_t cfg;
    xlen_t     mstatus_word;
    logic      mstatus_we;
    xlen_t     wdata;
    logic      mcause_we;
    xlen_t     mcause_val;

    csr_counters u_counters (
        .clk           (clk),
        .arst_n        (arst_n),
        .mtimecmp      (mtimecmp),
        .cycle         (cycle),
        .mtime         (mtime),
        .timer_pending (timer_pending)
    );

    csr_issue u_issue (
        .clk           (clk),
        .arst_n        (arst_n),
        .csr_cmd       (csr_cmd),
        .op1_data      (op1_data),
        .imm_i         (imm_i),
        .branch_hazard (branch_hazard),
        .req           (req)
    );

    csr_file u_file (
        .clk          (clk),
        .arst_n       (arst_n),
        .req          (req),
        .cycle        (cycle),
        .mtime        (mtime),
        .mstatus_word (mstatus_word),
        .mcause_we    (mcause_we),
        .mcause_val   (mcause_val),
        .rdata        (csr_rdata),
        .cfg          (cfg),
        .mstatus_we   (mstatus_we),
        .wdata        (wdata)
    );

    // Mode stays inside the trap unit here
    csr_trap u_trap (
        .clk                 (clk),
        .arst_n              (arst_n),
        .req                 (req),
        .cfg                 (cfg),
        .timer_pending       (timer_pending),
        .interrupt_ready     (interrupt_ready),
        .mstatus_we          (mstatus_we),
        .wdata               (wdata),
        .mstatus_word        (mstatus_word),
        .mode                (),
        .mcause_we           (mcause_we),
        .mcause_val          (mcause_val),
        .csr_cmd_out         (csr_cmd_out),
        .trap_vector         (trap_vector),
        .stall_may_interrupt (stall_may_interrupt)
    );

endmodule

// ==== verification/csr_tb_table.svh ====
// Columns are cmd, op1, addr, hazard, irq and mtimecmp
// then expected cmd_out, rdata, trap_vector, stall and check mask
// mscratch rows get LFSR operands and model rdata in the loop
localparam int NUM_ROWS = 34;

localparam row_t STIM [NUM_ROWS] = '{
    // Register access on mscratch
    '{CSR_W, 32'h0, MSCRATCH, 1'b0, 1'b0, NEVER, CSR_W, 32'h0, 32'h0, 1'b0, M_CR},
    '{CSR_X, 32'h0, MSCRATCH, 1'b0, 1'b0, NEVER, CSR_X, 32'h0, 32'h0, 1'b0, M_CR},
    '{CSR_S, 32'h0, MSCRATCH, 1'b0, 1'b0, NEVER, CSR_S, 32'h0, 32'h0, 1'b0, M_CR},
    '{CSR_X, 32'h0, MSCRATCH, 1'b0, 1'b0, NEVER, CSR_X, 32'h0, 32'h0, 1'b0, M_CR},
    '{CSR_C, 32'h0, MSCRATCH, 1'b0, 1'b0, NEVER, CSR_C, 32'h0, 32'h0, 1'b0, M_CR},
    '{CSR_X, 32'h0, MSCRATCH, 1'b0, 1'b0, NEVER, CSR_X, 32'h0, 32'h0, 1'b0, M_CR},
    // mtvec W, S, C then read back
    '{CSR_W, 32'h1000, MTVEC, 1'b0, 1'b0, NEVER, CSR_W, 32'h0, 32'h0, 1'b0, M_CR},
    '{CSR_S, 32'h0104, MTVEC, 1'b0, 1'b0, NEVER, CSR_S, 32'h1000, 32'h0, 1'b0, M_CR},
    '{CSR_C, 32'h0004, MTVEC, 1'b0, 1'b0, NEVER, CSR_C, 32'h1104, 32'h0, 1'b0, M_CR},
    '{CSR_X, 32'h0, MTVEC, 1'b0, 1'b0, NEVER, CSR_X, 32'h1100, 32'h0, 1'b0, M_CR},
    // Read-only and unimplemented
    '{CSR_W, 32'hffff_ffff, MISA, 1'b0, 1'b0, NEVER, CSR_W, 32'h0, 32'h0, 1'b0, M_CR},
    '{CSR_X, 32'h0, MISA, 1'b0, 1'b0, NEVER, CSR_X, 32'h0, 32'h0, 1'b0, M_CR},
    '{CSR_W, 32'h1234, 12'hf11, 1'b0, 1'b0, NEVER, CSR_W, 32'h0, 32'h0, 1'b0, M_CR},
    '{CSR_X, 32'h0, 12'hf11, 1'b0, 1'b0, NEVER, CSR_X, 32'h0, 32'h0, 1'b0, M_CR},
    // All ones into cycle would carry into the high half
    '{CSR_W, 32'hffff_ffff, CYCLE, 1'b0, 1'b0, NEVER, CSR_W, 32'h0, 32'h0, 1'b0, M_C},
    '{CSR_X, 32'h0, CYCLEH, 1'b0, 1'b0, NEVER, CSR_X, 32'h0, 32'h0, 1'b0, M_CR},
    // Killed write reads address fff as zero
    '{CSR_W, 32'h0, MSCRATCH, 1'b1, 1'b0, NEVER, CSR_X, 32'h0, 32'h0, 1'b0, M_CR},
    '{CSR_X, 32'h0, MSCRATCH, 1'b0, 1'b0, NEVER, CSR_X, 32'h0, 32'h0, 1'b0, M_CR},
    // ECALL from machine mode
    '{CSR_ECALL, 32'h0, 12'h0, 1'b0, 1'b0, NEVER, CSR_ECALL, 32'h0, 32'h1100, 1'b0, M_ALL},
    '{CSR_X, 32'h0, MCAUSE, 1'b0, 1'b0, NEVER, CSR_X, 32'hb, 32'h0, 1'b0, M_CR},
    // MRET to user mode, then ECALL from user
    '{CSR_W, 32'h2000, MEPC, 1'b0, 1'b0, NEVER, CSR_W, 32'h0, 32'h0, 1'b0, M_CR},
    '{CSR_W, 32'h0080, MSTATUS, 1'b0, 1'b0, NEVER, CSR_W, 32'h1800, 32'h0, 1'b0, M_CR},
    '{CSR_MRET, 32'h0, 12'h0, 1'b0, 1'b0, NEVER, CSR_MRET, 32'h0, 32'h2000, 1'b0, M_ALL},
    '{CSR_X, 32'h0, MSTATUS, 1'b0, 1'b0, NEVER, CSR_X, 32'h88, 32'h0, 1'b0, M_CR},
    '{CSR_ECALL, 32'h0, 12'h0, 1'b0, 1'b0, NEVER, CSR_ECALL, 32'h0, 32'h1100, 1'b0, M_ALL},
    '{CSR_X, 32'h0, MCAUSE, 1'b0, 1'b0, NEVER, CSR_X, 32'h8, 32'h0, 1'b0, M_CR},
    // Timer interrupt with a fresh mtvec and MIE off first
    '{CSR_W, 32'h1200, MTVEC, 1'b0, 1'b0, NEVER, CSR_W, 32'h1100, 32'h0, 1'b0, M_CR},
    '{CSR_C, 32'h8, MSTATUS, 1'b0, 1'b0, NEVER, CSR_C, 32'h88, 32'h0, 1'b0, M_CR},
    '{CSR_S, 32'h1 << MIE_MTIE_BIT, MIE, 1'b0, 1'b0, NOW, CSR_S, 32'h0, 32'h0, 1'b0, M_CR},
    '{CSR_X, 32'h0, MSTATUS, 1'b0, 1'b0, NOW, CSR_X, 32'h80, 32'h0, 1'b0, M_CS},
    '{CSR_S, 32'h8, MSTATUS, 1'b0, 1'b0, NOW, CSR_S, 32'h80, 32'h0, 1'b0, M_CS},
    '{CSR_X, 32'h0, MSTATUS, 1'b0, 1'b0, NOW, CSR_X, 32'h88, 32'h0, 1'b1, M_CS},
    '{CSR_X, 32'h0, 12'h0, 1'b0, 1'b1, NOW, CSR_ECALL, 32'h0, 32'h1200, 1'b0, M_TRAP},
    '{CSR_X, 32'h0, MSTATUS, 1'b0, 1'b0, NOW, CSR_X, 32'h1880, 32'h0, 1'b0, M_CS}
};

// ==== verification/csr_tb.sv ====
`timescale 1ns/100ps

module csr_tb;

    import csr_pkg::*;

    // One table row, stimulus then expected values
    typedef struct packed {
        csr_cmd_t  cmd;
        xlen_t     op1;
        csr_addr_t addr;
        logic      hazard;
        logic      irq;
        dword_t    timecmp;
        csr_cmd_t  exp_cmd;
        xlen_t     exp_rdata;
        xlen_t     exp_vec;
        logic      exp_stall;
        logic [3:0] mask;
    } row_t;

    // Check mask bits: cmd, rdata, vector, stall
    localparam logic [3:0] M_C    = 4'b0001;
    localparam logic [3:0] M_CR   = 4'b0011;
    localparam logic [3:0] M_ALL  = 4'b0111;
    localparam logic [3:0] M_CS   = 4'b1011;
    localparam logic [3:0] M_TRAP = 4'b1111;
    localparam dword_t NEVER = '1;
    localparam dword_t NOW   = '0;
    localparam row_t IDLE_ROW = '{CSR_X, 32'h0, 12'h0, 1'b0, 1'b0, NEVER,
                                  CSR_X, 32'h0, 32'h0, 1'b0, M_CR};

    `include "csr_tb_table.svh"

    // Each row may bring one idle slot, plus reset and drain
    localparam int WATCHDOG_NS = (2 * NUM_ROWS + 20) * 10;

    logic      clk = 1'b0;
    logic      arst_n;
    csr_cmd_t  csr_cmd;
    xlen_t     op1_data;
    xlen_t     imm_i;
    logic      branch_hazard;
    logic      interrupt_ready;
    dword_t    mtimecmp;
    csr_cmd_t  csr_cmd_out;
    xlen_t     csr_rdata;
    xlen_t     trap_vector;
    logic      stall_may_interrupt;

    // Scoreboard state
    row_t        pending[$];
    logic        irq_prev = 1'b0;
    logic [15:0] lfsr     = 16'd56176;
    xlen_t       scratch  = '0;
    int          errors   = 0;
    int          checks   = 0;

    csr_pipe UUT (
        .clk                 (clk),
        .arst_n              (arst_n),
        .csr_cmd             (csr_cmd),
        .op1_data            (op1_data),
        .imm_i               (imm_i),
        .branch_hazard       (branch_hazard),
        .interrupt_ready     (interrupt_ready),
        .mtimecmp            (mtimecmp),
        .csr_cmd_out         (csr_cmd_out),
        .csr_rdata           (csr_rdata),
        .trap_vector         (trap_vector),
        .stall_may_interrupt (stall_may_interrupt)
    );

    always #5 clk = ~clk;

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One LFSR step per operand bit
    task automatic draw_word(output xlen_t w);
        w = '0;
        for (int b = 0; b < 32; b++) begin
            lfsr = lfsr_step(lfsr);
            w = {w[30:0], lfsr[0]};
        end
    endtask

    function automatic logic is_write(input csr_cmd_t c);
        return (c == CSR_W) || (c == CSR_S) || (c == CSR_C);
    endfunction

    task automatic check_word(input string name, input xlen_t got, input xlen_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_cmd(input string name, input csr_cmd_t got, input csr_cmd_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_slot(input row_t r);
        if (r.mask[0]) check_cmd("csr_cmd_out", csr_cmd_out, r.exp_cmd);
        if (r.mask[1]) check_word("csr_rdata", csr_rdata, r.exp_rdata);
        if (r.mask[2]) check_word("trap_vector", trap_vector, r.exp_vec);
        if (r.mask[3]) check_flag("stall_may_interrupt", stall_may_interrupt, r.exp_stall);
    endtask

    // Drive one slot, check the slot issued two cycles earlier
    task automatic run_slot(input row_t r);
        @(posedge clk);
        csr_cmd         <= r.cmd;
        op1_data        <= r.op1;
        // Sign extended like a real I-immediate
        imm_i           <= {{20{r.addr[11]}}, r.addr};
        branch_hazard   <= r.hazard;
        mtimecmp        <= r.timecmp;
        // Ready lines up with the cycle the row sits in the issue register
        interrupt_ready <= irq_prev;
        irq_prev = r.irq;
        pending.push_back(r);
        @(negedge clk);
        if (pending.size() > 2) check_slot(pending.pop_front());
    endtask

    initial begin
        row_t  r;
        row_t  idle;
        xlen_t rnd;
        arst_n          <= 1'b0;
        csr_cmd         <= CSR_X;
        op1_data        <= '0;
        imm_i           <= '0;
        branch_hazard   <= 1'b0;
        interrupt_ready <= 1'b0;
        mtimecmp        <= NEVER;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        for (int i = 0; i < NUM_ROWS; i++) begin
            r = STIM[i];
            // mscratch data comes from the LFSR, expectation from the RMW rule
            if (r.addr == MSCRATCH && is_write(r.cmd)) begin
                draw_word(rnd);
                r.op1 = rnd;
            end
            if (r.addr == MSCRATCH && !r.hazard) begin
                r.exp_rdata = scratch;
                case (r.cmd)
                    CSR_W: scratch = r.op1;
                    CSR_S: scratch = scratch | r.op1;
                    CSR_C: scratch = scratch & ~r.op1;
                    default: ;
                endcase
            end
            run_slot(r);
            // No bypass, so a write is followed by a gap
            if (is_write(r.cmd)) begin
                idle = IDLE_ROW;
                idle.timecmp = r.timecmp;
                run_slot(idle);
            end
        end
        // Drain the last two slots
        idle = IDLE_ROW;
        idle.timecmp = r.timecmp;
        idle.mask = '0;
        repeat (2) run_slot(idle);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        #WATCHDOG_NS;
        $display("Watchdog expired after %0d ns before the table finished", WATCHDOG_NS);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("Test failures found");
        $finish;
    end

endmodule

// ==== csr_pipe.f ====
+incdir+verification
common/csr_pkg.sv
hdl/csr_counters.sv
csr_unit/csr_issue.sv
csr_unit/csr_file.sv
csr_unit/csr_trap.sv
hdl/csr_pipe.sv
verification/csr_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the CSR stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
    -f csr_pipe.f \
    --top-module csr_tb \
    -o csr_tb_sim

./obj_dir/csr_tb_sim > sim.log
cat sim.log

if grep -q "All tests passed!" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
